// File: logic/register_file.sv
`timescale 1ns/10ps
`include "wb_params.svh"

module register_file (
  input  logic                   clk,
  input  logic                   reset,
  input  wb_pkg::reg_write_t     reg_write,
  input  logic [`WB_REGNO_W-1:0] dbg_regno,
  output logic [`WB_XLEN-1:0]    dbg_data,
  output wb_pkg::syscall_args_t  args
);

  logic [`WB_XLEN-1:0] regs [`WB_REG_COUNT];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `WB_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_write.en && (reg_write.rd != '0)) begin
      // writes to x0 are discarded here.
      regs[reg_write.rd] <= reg_write.data;
    end
  end

  assign dbg_data = (dbg_regno == '0) ? '0 : regs[dbg_regno];

  // a0 to a7 are x10 to x17.
  assign args.a0 = regs[`WB_A0_REGNO];
  assign args.a1 = regs[`WB_A0_REGNO + 1];
  assign args.a2 = regs[`WB_A0_REGNO + 2];
  assign args.a3 = regs[`WB_A0_REGNO + 3];
  assign args.a4 = regs[`WB_A0_REGNO + 4];
  assign args.a5 = regs[`WB_A0_REGNO + 5];
  assign args.a6 = regs[`WB_A0_REGNO + 6];
  assign args.a7 = regs[`WB_A0_REGNO + 7];

endmodule

// File: logic/store_commit.sv
`timescale 1ns/10ps
`include "wb_params.svh"

module store_commit (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   store,
  input  wb_pkg::mem_size_e      size,
  input  logic [`WB_XLEN-1:0]    phy_addr,
  input  logic [`WB_XLEN-1:0]    rs2_value,
  output wb_pkg::mem_write_t     mem_write
);

  logic [2:0]         offset;
  logic [7:0]         base_mask;
  wb_pkg::mem_write_t mw_q;

  assign offset = phy_addr[2:0];

  // stores are naturally aligned, so the shifted mask never leaves the dword.
  always_comb begin
    case (size)
      wb_pkg::size_byte: base_mask = 8'h01;
      wb_pkg::size_half: base_mask = 8'h03;
      wb_pkg::size_word: base_mask = 8'h0f;
      default:           base_mask = 8'hff;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mw_q.en <= 1'b0;
    end else begin
      mw_q.en <= store;
    end
  end

  always_ff @(posedge clk) begin
    mw_q.addr      <= {phy_addr[`WB_XLEN-1:3], 3'b000};
    mw_q.byte_mask <= base_mask << offset;
    mw_q.data      <= rs2_value << {offset, 3'b000};
  end

  assign mem_write = mw_q;

endmodule

// File: logic/syscall_unit.sv
`timescale 1ns/10ps
`include "wb_params.svh"

module syscall_unit (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   scall,
  input  wb_pkg::syscall_args_t  args,
  output logic [`WB_XLEN-1:0]    sys_ret,
  output logic                   console_valid,
  output logic [7:0]             console_char,
  output logic                   halted,
  output logic [`WB_XLEN-1:0]    exit_code
);

  logic               is_write;
  logic               is_exit;
  logic [`WB_XLEN-1:0] ret_next;

  // the syscall number comes in a7.
  assign is_write = (args.a7 == `WB_XLEN'(`WB_SYS_WRITE));
  assign is_exit  = (args.a7 == `WB_XLEN'(`WB_SYS_EXIT));

  always_comb begin
    if (is_write) begin
      ret_next = `WB_XLEN'(1);
    end else if (is_exit) begin
      ret_next = args.a0;
    end else begin
      // unknown syscall numbers report failure.
      ret_next = '1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      console_valid <= 1'b0;
      halted        <= 1'b0;
      exit_code     <= '0;
    end else begin
      console_valid <= scall && is_write;
      if (scall && is_exit) begin
        // halted is sticky until the next reset.
        halted    <= 1'b1;
        exit_code <= args.a0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (scall) begin
      sys_ret      <= ret_next;
      console_char <= args.a0[7:0];
    end
  end

endmodule

// File: logic/wb_backend.sv
`timescale 1ns/10ps
`include "wb_params.svh"

module wb_backend (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   retire_valid,
  input  wb_pkg::retire_t        retire,
  output logic                   busy,
  output logic                   syscall_flush,
  output logic                   program_end,
  output wb_pkg::mem_write_t     mem_write,
  output logic                   console_valid,
  output logic [7:0]             console_char,
  output logic                   halted,
  output logic [`WB_XLEN-1:0]    exit_code,
  input  logic [`WB_REGNO_W-1:0] dbg_regno,
  output logic [`WB_XLEN-1:0]    dbg_data
);

  wb_pkg::reg_write_t    reg_write;
  wb_pkg::syscall_args_t args;
  logic [`WB_XLEN-1:0]   sys_ret;
  logic                  scall;
  logic                  store;

  // nothing retires in the busy cycle that follows a syscall.
  assign scall = retire_valid && !busy && (retire.op == wb_pkg::op_scall);
  assign store = retire_valid && !busy && (retire.op == wb_pkg::op_store);

  writeback i_writeback (
    .clk           (clk),
    .reset         (reset),
    .retire_valid  (retire_valid),
    .retire        (retire),
    .sys_ret       (sys_ret),
    .reg_write     (reg_write),
    .busy          (busy),
    .syscall_flush (syscall_flush),
    .program_end   (program_end)
  );

  syscall_unit i_syscall_unit (
    .clk           (clk),
    .reset         (reset),
    .scall         (scall),
    .args          (args),
    .sys_ret       (sys_ret),
    .console_valid (console_valid),
    .console_char  (console_char),
    .halted        (halted),
    .exit_code     (exit_code)
  );

  store_commit i_store_commit (
    .clk       (clk),
    .reset     (reset),
    .store     (store),
    .size      (retire.size),
    .phy_addr  (retire.phy_addr),
    .rs2_value (retire.rs2_value),
    .mem_write (mem_write)
  );

  register_file i_register_file (
    .clk       (clk),
    .reset     (reset),
    .reg_write (reg_write),
    .dbg_regno (dbg_regno),
    .dbg_data  (dbg_data),
    .args      (args)
  );

endmodule

// File: logic/wb_params.svh
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// data path and address width of the RV64 core.
`define WB_XLEN 64

// integer register file geometry.
`define WB_REG_COUNT 32
`define WB_REGNO_W 5

// a0 receives the syscall return value, a7 holds the syscall number.
`define WB_A0_REGNO 10

// syscall numbers understood by the syscall unit.
`define WB_SYS_WRITE 64
`define WB_SYS_EXIT 93

`endif

// File: logic/wb_pkg.sv
`include "wb_params.svh"

package wb_pkg;

  // class of the instruction that retires this cycle.
  typedef enum logic [2:0] {
    op_alu,
    op_load,
    op_store,
    op_scall,
    op_ret
  } wb_op_e;

  // store access width.
  typedef enum logic [1:0] {
    size_byte,
    size_half,
    size_word,
    size_dword
  } mem_size_e;

  typedef struct packed {
    wb_op_e                   op;
    mem_size_e                size;
    logic [`WB_REGNO_W-1:0]   rd;
    logic                     update_rd;
    logic                     branch_taken;
    logic [`WB_XLEN-1:0]      alu_result;
    logic [`WB_XLEN-1:0]      mdata;
    logic [`WB_XLEN-1:0]      rs2_value;
    logic [`WB_XLEN-1:0]      phy_addr;
  } retire_t;

  typedef struct packed {
    logic                     en;
    logic [`WB_REGNO_W-1:0]   rd;
    logic [`WB_XLEN-1:0]      data;
  } reg_write_t;

  // addr is 8-byte aligned and data already sits in its byte lanes.
  typedef struct packed {
    logic                     en;
    logic [`WB_XLEN-1:0]      addr;
    logic [`WB_XLEN-1:0]      data;
    logic [7:0]               byte_mask;
  } mem_write_t;

  typedef struct packed {
    logic [`WB_XLEN-1:0]      a0;
    logic [`WB_XLEN-1:0]      a1;
    logic [`WB_XLEN-1:0]      a2;
    logic [`WB_XLEN-1:0]      a3;
    logic [`WB_XLEN-1:0]      a4;
    logic [`WB_XLEN-1:0]      a5;
    logic [`WB_XLEN-1:0]      a6;
    logic [`WB_XLEN-1:0]      a7;
  } syscall_args_t;

endpackage

// File: logic/writeback.sv
`timescale 1ns/10ps
`include "wb_params.svh"

module writeback (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   retire_valid,
  input  wb_pkg::retire_t        retire,
  input  logic [`WB_XLEN-1:0]    sys_ret,
  output wb_pkg::reg_write_t     reg_write,
  output logic                   busy,
  output logic                   syscall_flush,
  output logic                   program_end
);

  // high for the one cycle after a syscall, while its return value is written.
  logic               pending;
  logic               accept;
  wb_pkg::reg_write_t wr_next;
  wb_pkg::reg_write_t wr_q;

  // an instruction presented while the return value is pending is dropped.
  assign accept = retire_valid && !pending;

  assign syscall_flush = accept && (retire.op == wb_pkg::op_scall);

  // a return that is not taken ends the program and writes nothing.
  assign program_end = accept && (retire.op == wb_pkg::op_ret) && !retire.branch_taken;

  assign busy = pending;

  always_comb begin
    wr_next.en   = 1'b0;
    wr_next.rd   = retire.rd;
    wr_next.data = retire.alu_result;

    if (pending) begin
      wr_next.en   = 1'b1;
      wr_next.rd   = `WB_REGNO_W'(`WB_A0_REGNO);
      wr_next.data = sys_ret;
    end else if (retire_valid) begin
      case (retire.op)
        wb_pkg::op_load: begin
          // loads always update their destination.
          wr_next.en   = 1'b1;
          wr_next.data = retire.mdata;
        end
        wb_pkg::op_alu: begin
          wr_next.en = retire.update_rd;
        end
        wb_pkg::op_ret: begin
          // a taken return links like any ALU result.
          wr_next.en = retire.branch_taken && retire.update_rd;
        end
        default: begin
          wr_next.en = 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
    end else begin
      pending <= syscall_flush;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_q.en <= 1'b0;
    end else begin
      wr_q.en <= wr_next.en;
    end
  end

  always_ff @(posedge clk) begin
    wr_q.rd   <= wr_next.rd;
    wr_q.data <= wr_next.data;
  end

  assign reg_write = wr_q;

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --timescale 1ns/10ps \
  --top-module tb_wb_backend \
  -f vlog.f \
  -o tb_wb_backend

# the log search below decides the result, also when the run stops early.
./obj_dir/tb_wb_backend > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi

echo "simulation finished without errors"
exit 0

// File: test/tb_wb_backend.sv
`timescale 1ns/10ps
`include "wb_params.svh"

module tb_wb_backend;

  // about 300 cycles are needed for the whole sequence.
  localparam int CYCLE_LIMIT = 3000;

  logic                   clk;
  logic                   reset;
  logic                   retire_valid;
  wb_pkg::retire_t        retire;
  logic                   busy;
  logic                   syscall_flush;
  logic                   program_end;
  wb_pkg::mem_write_t     mem_write;
  logic                   console_valid;
  logic [7:0]             console_char;
  logic                   halted;
  logic [`WB_XLEN-1:0]    exit_code;
  logic [`WB_REGNO_W-1:0] dbg_regno;
  logic [`WB_XLEN-1:0]    dbg_data;

  logic [`WB_XLEN-1:0]    ref_regs [`WB_REG_COUNT];
  logic [31:0]            rng_state;
  int                     cycle_count;

  // strobe values expected in the current cycle, set by the stimulus.
  logic                   flush_exp;
  logic                   end_exp;
  logic                   busy_exp;
  logic                   store_exp;
  logic                   console_exp;
  logic                   halted_exp;
  logic [`WB_XLEN-1:0]    exit_exp;

  wb_backend i_dut (
    .clk           (clk),
    .reset         (reset),
    .retire_valid  (retire_valid),
    .retire        (retire),
    .busy          (busy),
    .syscall_flush (syscall_flush),
    .program_end   (program_end),
    .mem_write     (mem_write),
    .console_valid (console_valid),
    .console_char  (console_char),
    .halted        (halted),
    .exit_code     (exit_code),
    .dbg_regno     (dbg_regno),
    .dbg_data      (dbg_data)
  );

  always #50 clk = ~clk;

  task automatic stop_run();
    $display("STATUS: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic fail_value(input string what);
    $display("Fail at %0t ns: %s", $time, what);
    stop_run();
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [`WB_XLEN-1:0] rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    return {hi, lo};
  endfunction

  function automatic wb_pkg::retire_t random_retire();
    wb_pkg::retire_t r;
    logic [31:0]     t;
    t              = next_rand();
    r.op           = wb_pkg::op_alu;
    r.size         = wb_pkg::mem_size_e'(t[1:0]);
    r.rd           = t[6:2];
    r.update_rd    = t[7];
    r.branch_taken = t[8];
    r.alu_result   = rand64();
    r.mdata        = rand64();
    r.rs2_value    = rand64();
    r.phy_addr     = rand64();
    return r;
  endfunction

  // register effect of one retired instruction, taken from the retirement rules.
  function automatic void apply_to_model(input wb_pkg::retire_t r,
                                         input logic [`WB_XLEN-1:0] a7,
                                         input logic [`WB_XLEN-1:0] a0);
    logic                   write;
    logic [`WB_REGNO_W-1:0] dest;
    logic [`WB_XLEN-1:0]    value;
    write = 1'b0;
    dest  = r.rd;
    value = r.alu_result;
    case (r.op)
      wb_pkg::op_load: begin
        write = 1'b1;
        value = r.mdata;
      end
      wb_pkg::op_alu: write = r.update_rd;
      wb_pkg::op_ret: write = r.branch_taken && r.update_rd;
      wb_pkg::op_scall: begin
        write = 1'b1;
        dest  = `WB_REGNO_W'(`WB_A0_REGNO);
        if (a7 == `WB_XLEN'(`WB_SYS_WRITE)) begin
          value = `WB_XLEN'(1);
        end else if (a7 == `WB_XLEN'(`WB_SYS_EXIT)) begin
          value = a0;
        end else begin
          value = '1;
        end
      end
      default: write = 1'b0;
    endcase
    if (write && (dest != '0)) begin
      ref_regs[dest] = value;
    end
  endfunction

  // starts 1 ns after an edge and returns 1 ns after an edge.
  task automatic run_instr(input wb_pkg::retire_t r);
    logic                   is_scall;
    logic                   is_store;
    logic [`WB_XLEN-1:0]    a0_before;
    logic [`WB_XLEN-1:0]    a7_before;
    logic [`WB_REGNO_W-1:0] check_regno;
    logic [15:0]            wide_mask;
    logic [`WB_XLEN-1:0]    exp_data;
    int                     offset;
    is_scall    = (r.op == wb_pkg::op_scall);
    is_store    = (r.op == wb_pkg::op_store);
    a0_before   = ref_regs[`WB_A0_REGNO];
    a7_before   = ref_regs[`WB_A0_REGNO + 7];
    check_regno = is_scall ? `WB_REGNO_W'(`WB_A0_REGNO) : r.rd;
    retire       = r;
    retire_valid = 1'b1;
    flush_exp    = is_scall;
    end_exp      = (r.op == wb_pkg::op_ret) && !r.branch_taken;
    @(posedge clk);
    #1;
    retire_valid = 1'b0;
    flush_exp    = 1'b0;
    end_exp      = 1'b0;
    busy_exp     = is_scall;
    store_exp    = is_store;
    console_exp  = is_scall && (a7_before == `WB_XLEN'(`WB_SYS_WRITE));
    if (is_scall && (a7_before == `WB_XLEN'(`WB_SYS_EXIT))) begin
      halted_exp = 1'b1;
      exit_exp   = a0_before;
    end
    @(negedge clk);
    if (is_store) begin
      offset    = int'(r.phy_addr[2:0]);
      wide_mask = ((16'd1 << (1 << int'(r.size))) - 16'd1) << offset;
      exp_data  = r.rs2_value << (8 * offset);
      assert (mem_write.addr == (r.phy_addr & ~`WB_XLEN'(7)))
        else fail_value($sformatf("store address %h from %h", mem_write.addr, r.phy_addr));
      assert (mem_write.byte_mask == wide_mask[7:0])
        else fail_value($sformatf("byte mask %h, expected %h", mem_write.byte_mask,
                                  wide_mask[7:0]));
      assert (mem_write.data == exp_data)
        else fail_value($sformatf("store data %h, expected %h", mem_write.data, exp_data));
    end
    if (console_exp) begin
      assert (console_char == a0_before[7:0])
        else fail_value($sformatf("console char %h, expected %h", console_char,
                                  a0_before[7:0]));
    end
    @(posedge clk);
    #1;
    busy_exp    = 1'b0;
    store_exp   = 1'b0;
    console_exp = 1'b0;
    // the return value reaches a0 one edge later than a normal write.
    if (is_scall) begin
      @(posedge clk);
      #1;
    end
    apply_to_model(r, a7_before, a0_before);
    dbg_regno = check_regno;
    @(negedge clk);
    assert (dbg_data == ref_regs[check_regno])
      else fail_value($sformatf("x%0d reads %h, expected %h", check_regno, dbg_data,
                                ref_regs[check_regno]));
    @(posedge clk);
    #1;
  endtask

  task automatic set_reg(input int regno, input logic [`WB_XLEN-1:0] value);
    wb_pkg::retire_t r;
    r            = random_retire();
    r.op         = wb_pkg::op_alu;
    r.rd         = `WB_REGNO_W'(regno);
    r.update_rd  = 1'b1;
    r.alu_result = value;
    run_instr(r);
  endtask

  task automatic do_syscall();
    wb_pkg::retire_t r;
    r    = random_retire();
    r.op = wb_pkg::op_scall;
    run_instr(r);
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: the test did not finish within %0d cycles", CYCLE_LIMIT);
      stop_run();
    end
  end

  always @(negedge clk) begin
    if (!reset) begin
      assert (program_end == end_exp)
        else fail_value($sformatf("program_end %b, expected %b", program_end, end_exp));
      assert (syscall_flush == flush_exp)
        else fail_value($sformatf("syscall_flush %b, expected %b", syscall_flush, flush_exp));
      assert (busy == busy_exp)
        else fail_value($sformatf("busy %b, expected %b", busy, busy_exp));
      assert (mem_write.en == store_exp)
        else fail_value($sformatf("mem_write.en %b, expected %b", mem_write.en, store_exp));
      assert (console_valid == console_exp)
        else fail_value($sformatf("console_valid %b, expected %b", console_valid, console_exp));
      assert (halted == halted_exp)
        else fail_value($sformatf("halted %b, expected %b", halted, halted_exp));
      assert (exit_code == exit_exp)
        else fail_value($sformatf("exit_code %h, expected %h", exit_code, exit_exp));
    end
  end

  initial begin
    wb_pkg::retire_t r;
    logic [31:0]     t;
    int              nbytes;
    clk          = 1'b0;
    reset        = 1'b1;
    retire_valid = 1'b0;
    retire       = '0;
    dbg_regno    = '0;
    rng_state    = 32'hd850_d1a5;
    cycle_count  = 0;
    flush_exp    = 1'b0;
    end_exp      = 1'b0;
    busy_exp     = 1'b0;
    store_exp    = 1'b0;
    console_exp  = 1'b0;
    halted_exp   = 1'b0;
    exit_exp     = '0;
    for (int i = 0; i < `WB_REG_COUNT; i++) begin
      ref_regs[i] = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    // ALU results, with a taken return now and then.
    for (int i = 0; i < 40; i++) begin
      r              = random_retire();
      t              = next_rand();
      r.op           = (t[2:0] == 3'd0) ? wb_pkg::op_ret : wb_pkg::op_alu;
      r.branch_taken = 1'b1;
      run_instr(r);
    end

    for (int i = 0; i < 16; i++) begin
      r    = random_retire();
      r.op = wb_pkg::op_load;
      run_instr(r);
    end

    // every size at every naturally aligned offset, twice.
    for (int pass = 0; pass < 2; pass++) begin
      for (int s = 0; s < 4; s++) begin
        nbytes = 1 << s;
        for (int off = 0; off < 8; off += nbytes) begin
          r          = random_retire();
          r.op       = wb_pkg::op_store;
          r.size     = wb_pkg::mem_size_e'(s);
          r.phy_addr = {r.phy_addr[`WB_XLEN-1:3], 3'(off)};
          run_instr(r);
        end
      end
    end

    set_reg(`WB_A0_REGNO, rand64());
    set_reg(`WB_A0_REGNO + 7, `WB_XLEN'(`WB_SYS_WRITE));
    do_syscall();

    // the top bit keeps this number away from every known syscall.
    set_reg(`WB_A0_REGNO + 7, {1'b1, 63'(rand64())});
    do_syscall();

    for (int i = 0; i < 2; i++) begin
      r              = random_retire();
      r.op           = wb_pkg::op_ret;
      r.branch_taken = 1'b0;
      r.update_rd    = 1'b1;
      run_instr(r);
    end

    set_reg(`WB_A0_REGNO, rand64());
    set_reg(`WB_A0_REGNO + 7, `WB_XLEN'(`WB_SYS_EXIT));
    do_syscall();

    r    = random_retire();
    r.op = wb_pkg::op_alu;
    run_instr(r);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+logic
logic/wb_pkg.sv
logic/writeback.sv
logic/syscall_unit.sv
logic/store_commit.sv
logic/register_file.sv
logic/wb_backend.sv
test/tb_wb_backend.sv
